//--- all.f
+incdir+include
src/omdcPkg.sv
src/ctrlRegs.sv
src/columnScanner.sv
src/rowScanner.sv
src/laneControl.sv
src/omdcTop.sv
verif/omdc_assertions.sv
verif/omdcTb.sv

//--- Makefile
# Verilator build and run of the dataflow controller testbench

VERILATOR ?= verilator
TOP       ?= omdcTb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= Everything OK
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
	  echo "Simulation passed"; \
	else \
	  echo "Simulation did not pass, see $(LOG)"; \
	  exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verif/omdcTb.sv
// Testbench for omdcTop with random runs checked cycle by cycle against a scan model
`include "omdc_settings.svh"

module omdcTb
  import omdcPkg::*;
();

  localparam int NumRuns   = 12;
  localparam int MaxPixels = 12 * 14;
  localparam int ClkPeriod = 10;
  // Random runs plus register, illegal, abort and restart runs
  localparam int TimeLimit = (NumRuns + 4) * MaxPixels * 4 * ClkPeriod + 20000;

  logic       omdcClk;
  logic       rstN;
  logic       pixelValid;
  wbReqT      wbReq;
  wbRspT      wbRsp;
  laneCtlVecT laneCtl;
  logic       chanSelEn;
  logic       newChannel;

  // Model copies of the configuration and scan position
  int         mCols, mRows, mWc, mWr, mSt;
  int         mc, mr;
  logic       mRun;
  laneCtlVecT expLanes;
  logic       expChan;
  logic       expNew;

  int         laneErrs, flagErrs, wordErrs, otherErrs;
  string      testName;

  omdcTop dut_i (
    .omdcClk    (omdcClk),
    .rstN       (rstN),
    .wbReq      (wbReq),
    .wbRsp      (wbRsp),
    .pixelValid (pixelValid),
    .laneCtl    (laneCtl),
    .chanSelEn  (chanSelEn),
    .newChannel (newChannel)
  );

  initial begin
    omdcClk = 1'b0;
    forever #(ClkPeriod / 2) omdcClk = ~omdcClk;
  end

  initial begin
    #(TimeLimit);
    $display("Watchdog expired at time %0t, the run did not finish", $time);
    $display("Something failed");
    $finish;
  end

  // ====================================================================
  // Compare tasks
  // ====================================================================
  task automatic checkLanes(input string name, input laneCtlVecT exp, input laneCtlVecT act);
    if (act !== exp) begin
      laneErrs++;
      $display("FAIL %s lanes expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic checkFlag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      flagErrs++;
      $display("FAIL %s expected %b actual %b", name, exp, act);
    end
  endtask

  task automatic checkWord(input string name, input wbDatT exp, input wbDatT act);
    if (act !== exp) begin
      wordErrs++;
      $display("FAIL %s expected %h actual %h", name, exp, act);
    end
  endtask

  // ====================================================================
  // Scan model
  // ====================================================================
  function automatic logic windowHit(input int pos, input int kSize, input int stride);
    return (pos >= kSize - 1) && (((pos - (kSize - 1)) % stride) == 0);
  endfunction

  // Expected outputs for the beat driven now, then step the position
  task automatic predictCycle(input logic pv);
    logic colOk, rowOk, rowLast;
    int   lane;
    expLanes = '0;
    expChan  = 1'b0;
    expNew   = 1'b0;
    if (pv && mRun) begin
      colOk   = windowHit(mc, mWc, mSt);
      rowOk   = windowHit(mr, mWr, mSt);
      rowLast = (mc == mCols - 1);
      lane    = mr % mWr;
      for (int i = 0; i < mWr; i++) begin
        expLanes[i].setEn  = (i == lane);
        expLanes[i].wptClr = (i == lane) && (mc == 0);
        expLanes[i].oEn    = colOk && rowOk;
        expLanes[i].rptClr = rowLast && rowOk;
      end
      expChan = colOk && rowOk;
      expNew  = rowLast && (mr == mRows - 1);
      if (rowLast) begin
        mc = 0;
        mr++;
        if (mr == mRows) begin
          mRun = 1'b0;
        end
      end else begin
        mc++;
      end
    end
  endtask

  // Check last cycle's outputs, then drive the next input
  task automatic tick(input logic pv);
    @(negedge omdcClk);
    checkLanes(testName, expLanes, laneCtl);
    checkFlag({testName, " chanSelEn"}, expChan, chanSelEn);
    checkFlag({testName, " newChannel"}, expNew, newChannel);
    predictCycle(pv);
    pixelValid = pv;
  endtask

  // ====================================================================
  // Wishbone master
  // ====================================================================
  task automatic wbXfer(input logic we, input wbAdrT adr, input wbDatT dat,
                        output wbDatT rd);
    int waitCnt;
    tick(1'b0);
    wbReq.cyc = 1'b1;
    wbReq.stb = 1'b1;
    wbReq.we  = we;
    wbReq.adr = adr;
    wbReq.dat = dat;
    waitCnt   = 1;
    tick(1'b0);
    while (!wbRsp.ack && waitCnt < 8) begin
      tick(1'b0);
      waitCnt++;
    end
    if (!wbRsp.ack) begin
      otherErrs++;
      $display("No Wishbone ack for a transfer to address %0d", adr);
    end
    rd = wbRsp.dat;
    // Request stays up one more cycle to see that the ack is not repeated
    tick(1'b0);
    if (wbRsp.ack) begin
      otherErrs++;
      $display("Wishbone ack was given twice for one transfer to address %0d", adr);
    end
    wbReq = '0;
  endtask

  task automatic wbWrite(input wbAdrT adr, input wbDatT dat);
    wbDatT unused;
    wbXfer(1'b1, adr, dat, unused);
  endtask

  task automatic checkReg(input string name, input wbAdrT adr, input wbDatT exp);
    wbDatT rd;
    wbXfer(1'b0, adr, '0, rd);
    checkWord(name, exp, rd);
  endtask

  // ====================================================================
  // Run helpers
  // ====================================================================
  task automatic writeConfig(input int wc, input int wr, input int st,
                             input int cols, input int rows);
    wbWrite(`OMDC_ADR_KERNEL, wbDatT'((st << 8) | (wr << 4) | wc));
    wbWrite(`OMDC_ADR_IFCOLS, wbDatT'(cols));
    wbWrite(`OMDC_ADR_IFROWS, wbDatT'(rows));
    mWc   = wc;
    mWr   = wr;
    mSt   = st;
    mCols = cols;
    mRows = rows;
  endtask

  // RUN is entered the edge after the ack, before the next drive
  task automatic startRun(input logic legal);
    wbWrite(`OMDC_ADR_CTRL, 32'h1);
    mc   = 0;
    mr   = 0;
    mRun = legal;
  endtask

  task automatic runPixels();
    while (mRun) begin
      tick($urandom_range(3, 0) != 0);
    end
    tick(1'b0);
  endtask

  // ====================================================================
  // Test sequence
  // ====================================================================
  initial begin
    int cols, rows, wc, wr, st;
    rstN       = 1'b0;
    pixelValid = 1'b0;
    wbReq      = '0;
    mRun       = 1'b0;
    mc         = 0;
    mr         = 0;
    mCols      = 1;
    mRows      = 1;
    mWc        = 1;
    mWr        = 1;
    mSt        = 1;
    expLanes   = '0;
    expChan    = 1'b0;
    expNew     = 1'b0;
    laneErrs   = 0;
    flagErrs   = 0;
    wordErrs   = 0;
    otherErrs  = 0;
    testName   = "reset";
    void'($urandom(92233));

    repeat (4) @(negedge omdcClk);
    rstN = 1'b1;

    testName = "registers";
    writeConfig(3, 5, 2, 100, 200);
    checkReg("kernel readback", `OMDC_ADR_KERNEL, 32'h253);
    checkReg("ifCols readback", `OMDC_ADR_IFCOLS, 32'd100);
    checkReg("ifRows readback", `OMDC_ADR_IFROWS, 32'd200);
    checkReg("idle status", `OMDC_ADR_CTRL, 32'h0);

    testName = "illegal";
    writeConfig(3, 14, 1, 20, 20);
    startRun(1'b0);
    checkReg("wRows 14 status", `OMDC_ADR_CTRL, 32'h4);
    writeConfig(8, 2, 1, 5, 6);
    startRun(1'b0);
    checkReg("wide kernel status", `OMDC_ADR_CTRL, 32'h4);

    // Small maps, any legal kernel and stride
    for (int run = 0; run < NumRuns; run++) begin
      testName = $sformatf("random run %0d", run);
      cols = int'($urandom_range(12, 2));
      rows = int'($urandom_range(14, 2));
      wc   = int'($urandom_range((cols > 15) ? 15 : cols, 1));
      wr   = int'($urandom_range((rows > 13) ? 13 : rows, 1));
      st   = int'($urandom_range(5, 1));
      writeConfig(wc, wr, st, cols, rows);
      startRun(1'b1);
      runPixels();
      checkReg({testName, " done status"}, `OMDC_ADR_CTRL, 32'h2);
      repeat (6) tick(1'b1);
      tick(1'b0);
    end

    testName = "abort";
    writeConfig(3, 3, 2, 8, 8);
    startRun(1'b1);
    repeat (20) tick(1'b1);
    mRun = 1'b0;
    wbWrite(`OMDC_ADR_CTRL, 32'h2);
    checkReg("abort status", `OMDC_ADR_CTRL, 32'h0);

    testName = "restart";
    startRun(1'b1);
    runPixels();
    checkReg("restart status", `OMDC_ADR_CTRL, 32'h2);

    $display("Error counts: lanes %0d, flags %0d, words %0d, other %0d",
             laneErrs, flagErrs, wordErrs, otherErrs);
    if (laneErrs + flagErrs + wordErrs + otherErrs == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

//--- verif/omdc_assertions.sv
// Concurrent checks on the controller top level, attached to omdcTop by bind
`include "omdc_settings.svh"

module omdcAssertions
  import omdcPkg::*;
(
  input logic       omdcClk,
  input logic       rstN,
  input wbRspT      wbRsp,
  input laneCtlVecT laneCtl,
  input convCfgT    cfg
);

  logic [`OMDC_NUM_LANES-1:0] setEnBits;
  logic                       upperIdle;

  // Write enables gathered, and lanes above the kernel height watched
  always_comb begin
    setEnBits = '0;
    upperIdle = 1'b1;
    for (int i = 0; i < `OMDC_NUM_LANES; i++) begin
      setEnBits[i] = laneCtl[i].setEn;
      if ((laneIdxT'(i) >= cfg.wRows) && (laneCtl[i] != '0)) begin
        upperIdle = 1'b0;
      end
    end
  end

  ackPulse: assert property (@(posedge omdcClk) disable iff (!rstN)
    wbRsp.ack |=> !wbRsp.ack)
    else $error("Wishbone ack held high for two cycles");

  setEnOneHot: assert property (@(posedge omdcClk) disable iff (!rstN)
    $onehot0(setEnBits))
    else $error("More than one lane written in the same cycle");

  upperLanesIdle: assert property (@(posedge omdcClk) disable iff (!rstN)
    upperIdle)
    else $error("Lane at or above the kernel height is active");

endmodule

bind omdcTop omdcAssertions omdcAssertions_i (
  .omdcClk (omdcClk),
  .rstN    (rstN),
  .wbRsp   (wbRsp),
  .laneCtl (laneCtl),
  .cfg     (cfg)
);

//--- src/omdcTop.sv
// Top level of the dataflow controller that connects the register block, scanners and lane stage
module omdcTop
  import omdcPkg::*;
(
  input  logic       omdcClk,
  input  logic       rstN,
  input  wbReqT      wbReq,
  output wbRspT      wbRsp,
  input  logic       pixelValid,
  output laneCtlVecT laneCtl,
  output logic       chanSelEn,
  output logic       newChannel
);

  convCfgT cfg;
  logic    beat;
  logic    scanClear;
  logic    colHit;
  logic    rowEnd;
  logic    firstCol;
  laneIdxT lane;
  logic    rowHit;
  logic    lastRow;
  logic    lastPixel;

  // Last column of the last row
  assign lastPixel = rowEnd && lastRow;

  ctrlRegs ctrlRegs_i (
    .omdcClk    (omdcClk),
    .rstN       (rstN),
    .wbReq      (wbReq),
    .wbRsp      (wbRsp),
    .pixelValid (pixelValid),
    .lastPixel  (lastPixel),
    .cfg        (cfg),
    .beat       (beat),
    .scanClear  (scanClear)
  );

  columnScanner columnScanner_i (
    .omdcClk   (omdcClk),
    .rstN      (rstN),
    .scanClear (scanClear),
    .beat      (beat),
    .cfg       (cfg),
    .colHit    (colHit),
    .rowEnd    (rowEnd),
    .firstCol  (firstCol)
  );

  rowScanner rowScanner_i (
    .omdcClk   (omdcClk),
    .rstN      (rstN),
    .scanClear (scanClear),
    .beat      (beat),
    .rowEnd    (rowEnd),
    .cfg       (cfg),
    .lane      (lane),
    .rowHit    (rowHit),
    .lastRow   (lastRow)
  );

  laneControl laneControl_i (
    .omdcClk    (omdcClk),
    .rstN       (rstN),
    .beat       (beat),
    .colHit     (colHit),
    .rowEnd     (rowEnd),
    .rowHit     (rowHit),
    .lastRow    (lastRow),
    .firstCol   (firstCol),
    .lane       (lane),
    .wRows      (cfg.wRows),
    .laneCtl    (laneCtl),
    .chanSelEn  (chanSelEn),
    .newChannel (newChannel)
  );

endmodule

//--- src/laneControl.sv
// Registered per-lane FIFO controls and channel flags built from both scan results
`include "omdc_settings.svh"

module laneControl
  import omdcPkg::*;
(
  input  logic       omdcClk,
  input  logic       rstN,
  input  logic       beat,
  input  logic       colHit,
  input  logic       rowEnd,
  input  logic       rowHit,
  input  logic       lastRow,
  input  logic       firstCol,
  input  laneIdxT    lane,
  input  wRowT       wRows,
  output laneCtlVecT laneCtl,
  output logic       chanSelEn,
  output logic       newChannel
);

  laneCtlVecT ctlNext;
  logic       chanSelNext;
  logic       winOut;
  logic       rdRewind;

  // Window complete, and last window column of the row
  assign winOut   = beat && colHit && rowHit;
  assign rdRewind = beat && rowEnd && rowHit;

  always_comb begin
    ctlNext     = '0;
    chanSelNext = 1'b0;
    for (int i = 0; i < `OMDC_NUM_LANES; i++) begin
      if (laneIdxT'(i) < wRows) begin
        ctlNext[i].setEn  = beat && (lane == laneIdxT'(i));
        ctlNext[i].wptClr = beat && (lane == laneIdxT'(i)) && firstCol;
        ctlNext[i].oEn    = winOut;
        ctlNext[i].rptClr = rdRewind;
        // Channel select follows the top enabled lane
        if (laneIdxT'(i) == laneIdxT'(wRows - 1'b1)) begin
          chanSelNext = winOut;
        end
      end
    end
  end

  always_ff @(posedge omdcClk) begin
    if (!rstN) begin
      laneCtl    <= '0;
      chanSelEn  <= 1'b0;
      newChannel <= 1'b0;
    end else begin
      laneCtl    <= ctlNext;
      chanSelEn  <= chanSelNext;
      newChannel <= beat && rowEnd && lastRow;
    end
  end

endmodule

//--- src/rowScanner.sv
// Row counter with lane rotation and row stride phase, stepped at each row end
module rowScanner
  import omdcPkg::*;
(
  input  logic    omdcClk,
  input  logic    rstN,
  input  logic    scanClear,
  input  logic    beat,
  input  logic    rowEnd,
  input  convCfgT cfg,
  output laneIdxT lane,
  output logic    rowHit,
  output logic    lastRow
);

  ifRowT  row;
  strideT phase;
  ifRowT  rowEdge;
  logic   pastEdge;
  logic   rowStep;

  // First row where the whole kernel height is buffered
  assign rowEdge  = ifRowT'(cfg.wRows) - 1'b1;
  assign pastEdge = (row >= rowEdge);

  assign rowHit  = pastEdge && (phase == '0);
  assign lastRow = (row == cfg.ifRows - 1'b1);
  assign rowStep = beat && rowEnd;

  // ====================================================================
  // Row, lane pointer and stride phase
  // ====================================================================
  always_ff @(posedge omdcClk) begin
    if (!rstN) begin
      row   <= '0;
      lane  <= '0;
      phase <= '0;
    end else if (scanClear) begin
      row   <= '0;
      lane  <= '0;
      phase <= '0;
    end else if (rowStep) begin
      if (lastRow) begin
        row   <= '0;
        lane  <= '0;
        phase <= '0;
      end else begin
        row <= row + 1'b1;

        // Lane is the row modulo the kernel height
        if (lane == laneIdxT'(cfg.wRows - 1'b1)) begin
          lane <= '0;
        end else begin
          lane <= lane + 1'b1;
        end

        if (pastEdge) begin
          if (phase == cfg.stride - 1'b1) begin
            phase <= '0;
          end else begin
            phase <= phase + 1'b1;
          end
        end
      end
    end
  end

endmodule

//--- src/columnScanner.sv
// Column counter and stride phase that feed the row scanner and lane stage from the top level
module columnScanner
  import omdcPkg::*;
(
  input  logic    omdcClk,
  input  logic    rstN,
  input  logic    scanClear,
  input  logic    beat,
  input  convCfgT cfg,
  output logic    colHit,
  output logic    rowEnd,
  output logic    firstCol
);

  ifColT  col;
  strideT phase;
  ifColT  colEdge;
  logic   pastEdge;

  // First column where the whole kernel width is present
  assign colEdge  = ifColT'(cfg.wCols) - 1'b1;
  assign pastEdge = (col >= colEdge);

  assign colHit   = pastEdge && (phase == '0);
  assign rowEnd   = (col == cfg.ifCols - 1'b1);
  assign firstCol = (col == '0);

  // ====================================================================
  // Column and stride phase
  // ====================================================================
  always_ff @(posedge omdcClk) begin
    if (!rstN) begin
      col   <= '0;
      phase <= '0;
    end else if (scanClear) begin
      col   <= '0;
      phase <= '0;
    end else if (beat) begin
      if (rowEnd) begin
        col   <= '0;
        phase <= '0;
      end else begin
        col <= col + 1'b1;
        // Phase only runs once the kernel edge is reached
        if (pastEdge) begin
          if (phase == cfg.stride - 1'b1) begin
            phase <= '0;
          end else begin
            phase <= phase + 1'b1;
          end
        end
      end
    end
  end

endmodule

//--- src/ctrlRegs.sv
// Wishbone register slave with configuration check and run FSM, feeding both scanners
`include "omdc_settings.svh"

module ctrlRegs
  import omdcPkg::*;
(
  input  logic    omdcClk,
  input  logic    rstN,
  input  wbReqT   wbReq,
  output wbRspT   wbRsp,
  input  logic    pixelValid,
  input  logic    lastPixel,
  output convCfgT cfg,
  output logic    beat,
  output logic    scanClear
);

  runStateT state;
  logic     ackQ;
  wbDatT    rdData;
  wbDatT    rdMux;
  logic     cfgErr;
  logic     startPend;
  logic     newReq;
  logic     wrReq;
  logic     ctrlWr;
  logic     cfgBad;
  logic     busy;

  // A transfer is taken in the cycle before its ack
  assign newReq = wbReq.cyc && wbReq.stb && !ackQ;
  assign wrReq  = newReq && wbReq.we;
  assign ctrlWr = wrReq && (wbReq.adr == `OMDC_ADR_CTRL);

  assign busy  = (state == RUN);
  assign beat  = pixelValid && busy;
  assign wbRsp = {ackQ, rdData};

  // ====================================================================
  // Register port
  // ====================================================================
  always_comb begin
    rdMux = '0;
    case (wbReq.adr)
      `OMDC_ADR_KERNEL: rdMux[11:0] = {cfg.stride, cfg.wRows, cfg.wCols};
      `OMDC_ADR_IFCOLS: rdMux[`OMDC_IFCOL_W-1:0] = cfg.ifCols;
      `OMDC_ADR_IFROWS: rdMux[`OMDC_IFROW_W-1:0] = cfg.ifRows;
      default:          rdMux[2:0] = {cfgErr, state == DONE, busy};
    endcase
  end

  always_ff @(posedge omdcClk) begin
    if (!rstN) begin
      ackQ <= 1'b0;
    end else begin
      ackQ <= newReq;
    end
  end

  always_ff @(posedge omdcClk) begin
    if (newReq) begin
      rdData <= rdMux;
    end
  end

  // Setup is frozen for the length of a run
  always_ff @(posedge omdcClk) begin
    if (!rstN) begin
      cfg <= '0;
    end else if (wrReq && !busy) begin
      case (wbReq.adr)
        `OMDC_ADR_KERNEL: begin
          cfg.wCols  <= wbReq.dat[3:0];
          cfg.wRows  <= wbReq.dat[7:4];
          cfg.stride <= wbReq.dat[11:8];
        end
        `OMDC_ADR_IFCOLS: cfg.ifCols <= wbReq.dat[`OMDC_IFCOL_W-1:0];
        `OMDC_ADR_IFROWS: cfg.ifRows <= wbReq.dat[`OMDC_IFROW_W-1:0];
        default: ;
      endcase
    end
  end

  // ====================================================================
  // Run FSM
  // ====================================================================
  assign cfgBad = (cfg.wRows == '0) || (cfg.wRows > wRowT'(`OMDC_NUM_LANES)) ||
                  (cfg.wCols == '0) || (cfg.stride == '0) ||
                  (ifColT'(cfg.wCols) > cfg.ifCols) ||
                  (ifRowT'(cfg.wRows) > cfg.ifRows);

  // Scanners restart on the same edge that enters RUN
  assign scanClear = startPend && !cfgBad && !busy;

  always_ff @(posedge omdcClk) begin
    if (!rstN) begin
      state     <= IDLE;
      cfgErr    <= 1'b0;
      startPend <= 1'b0;
    end else begin
      startPend <= ctrlWr && wbReq.dat[0] && !wbReq.dat[1];
      if (ctrlWr && wbReq.dat[1]) begin
        state <= IDLE;
      end else begin
        case (state)
          IDLE, DONE: begin
            if (startPend) begin
              if (cfgBad) begin
                cfgErr <= 1'b1;
              end else begin
                cfgErr <= 1'b0;
                state  <= RUN;
              end
            end
          end
          RUN: begin
            if (beat && lastPixel) begin
              state <= DONE;
            end
          end
          default: state <= IDLE;
        endcase
      end
    end
  end

endmodule

//--- src/omdcPkg.sv
// Shared types of the dataflow controller, imported by every module and the testbench
`include "omdc_settings.svh"

package omdcPkg;

  // ====================================================================
  // Field types
  // ====================================================================
  typedef logic [`OMDC_WCOL_W-1:0]   wColT;
  typedef logic [`OMDC_WROW_W-1:0]   wRowT;
  typedef logic [`OMDC_STRIDE_W-1:0] strideT;
  typedef logic [`OMDC_IFCOL_W-1:0]  ifColT;
  typedef logic [`OMDC_IFROW_W-1:0]  ifRowT;
  typedef logic [3:0]                laneIdxT;

  typedef logic [`OMDC_WB_ADR_W-1:0] wbAdrT;
  typedef logic [`OMDC_WB_DAT_W-1:0] wbDatT;

  // Convolution setup as held in the register block
  typedef struct packed {
    wColT   wCols;
    wRowT   wRows;
    strideT stride;
    ifColT  ifCols;
    ifRowT  ifRows;
  } convCfgT;

  // ====================================================================
  // Wishbone classic
  // ====================================================================
  typedef struct packed {
    logic  cyc;
    logic  stb;
    logic  we;
    wbAdrT adr;
    wbDatT dat;
  } wbReqT;

  typedef struct packed {
    logic  ack;
    wbDatT dat;
  } wbRspT;

  // Controls of one row FIFO
  typedef struct packed {
    logic setEn;
    logic oEn;
    logic wptClr;
    logic rptClr;
  } laneCtlT;

  typedef laneCtlT [`OMDC_NUM_LANES-1:0] laneCtlVecT;

  typedef enum logic [1:0] {
    IDLE,
    RUN,
    DONE
  } runStateT;

endpackage

//--- include/omdc_settings.svh
// Lane count, field widths and register map of the dataflow controller, included where needed
`ifndef OMDC_SETTINGS_SVH
`define OMDC_SETTINGS_SVH

// Row FIFOs driven by the controller
`define OMDC_NUM_LANES 13

// Configuration field widths, each holding the actual count
`define OMDC_WCOL_W    4
`define OMDC_WROW_W    4
`define OMDC_STRIDE_W  4
`define OMDC_IFCOL_W   11
`define OMDC_IFROW_W   10

// Wishbone register port
`define OMDC_WB_ADR_W  2
`define OMDC_WB_DAT_W  32

// Register addresses
`define OMDC_ADR_KERNEL 2'd0
`define OMDC_ADR_IFCOLS 2'd1
`define OMDC_ADR_IFROWS 2'd2
`define OMDC_ADR_CTRL   2'd3

`endif
